//--- design/div_macros.svh
/*
  divide unit constants: operand width, request queue depth, credit counter width
*/
`ifndef DIV_MACROS_SVH
`define DIV_MACROS_SVH

// operand width in bits
`define DIV_XLEN 32

// request queue entries
// also the number of request credits the requester holds after reset
`define DIV_QUEUE_DEPTH 4

// width of a credit counter
// must hold at least the largest number of outstanding credits
`define DIV_CREDIT_W 3

`endif

//--- design/div_pkg.sv
/*
  divide unit package
  opcode and state enums, request and response packed structs
*/
`default_nettype none

`include "div_macros.svh"

package div_pkg;

  // ----------------------------------------------------------
  // opcodes and FSM states
  // ----------------------------------------------------------

  // signed divide negates operands into magnitudes first
  typedef enum logic [0:0] {
    DIV_UNSIGNED = 1'b0,
    DIV_SIGNED   = 1'b1
  } div_fn_e;

  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_CALC = 2'd1,
    ST_DONE = 2'd2
  } div_state_e;

  // ----------------------------------------------------------
  // messages
  // ----------------------------------------------------------

  // 65 bit request, fn in the top bit
  typedef struct packed {
    div_fn_e               fn;
    logic [`DIV_XLEN-1:0]  a;
    logic [`DIV_XLEN-1:0]  b;
  } div_req_t;

  // 64 bit result, remainder above quotient
  typedef struct packed {
    logic [`DIV_XLEN-1:0]  rem;
    logic [`DIV_XLEN-1:0]  quot;
  } div_resp_t;

endpackage

`default_nettype wire

//--- design/div_req_queue.sv
/*
  divide request queue
  circular buffer that returns one request credit per released entry
*/
`timescale 1ns/1ps
`default_nettype none

`include "div_macros.svh"

module div_req_queue #(
  parameter int DEPTH = `DIV_QUEUE_DEPTH
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             req_valid,
  input  div_pkg::div_req_t req,
  input  logic             deq_pop,
  output logic             deq_valid,
  output div_pkg::div_req_t deq_req,
  output logic             req_credit
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  // entry storage, payload only
  div_pkg::div_req_t mem [DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;

  // ----------------------------------------------------------
  // storage write
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (req_valid) begin
      mem[wr_ptr] <= req;
    end
  end

  // ----------------------------------------------------------
  // pointers, occupancy and credit return
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      req_credit <= 1'b0;
    end else begin
      // explicit wrap so a non power of two depth still works
      if (req_valid) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (deq_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // push and pop together leave occupancy unchanged
      if (req_valid && !deq_pop) begin
        count <= count + 1'b1;
      end else if (!req_valid && deq_pop) begin
        count <= count - 1'b1;
      end
      // one credit per released entry, a cycle after the pop
      req_credit <= deq_pop;
    end
  end

  // head entry is visible the cycle after its write
  assign deq_valid = (count != '0);
  assign deq_req   = mem[rd_ptr];

  // requester spent a credit it did not own
  a_no_push_full: assert property (@(posedge clk) disable iff (reset)
    req_valid |-> (count != CNT_W'(DEPTH)));

  // divider took an entry that was never there
  a_no_pop_empty: assert property (@(posedge clk) disable iff (reset)
    deq_pop |-> (count != '0));

endmodule

`default_nettype wire

//--- design/div_ctrl.sv
/*
  divider control FSM
  accepts one request, sequences the iterations, holds the response credit count
*/
`timescale 1ns/1ps
`default_nettype none

`include "div_macros.svh"

module div_ctrl (
  input  logic clk,
  input  logic reset,
  input  logic deq_valid,
  output logic deq_pop,
  input  logic resp_credit,
  output logic resp_valid,
  input  logic sub_neg,
  input  logic count_zero,
  output logic load,
  output logic step
);

  div_pkg::div_state_e state;
  div_pkg::div_state_e state_next;

  // credits granted by the sink and not yet spent
  logic [`DIV_CREDIT_W-1:0] credit_cnt;

  // ----------------------------------------------------------
  // control outputs
  // ----------------------------------------------------------

  // take the head entry whenever idle and one is there
  assign deq_pop    = (state == div_pkg::ST_IDLE) && deq_valid;
  // operands land in the datapath on the pop edge
  assign load       = deq_pop;
  assign step       = (state == div_pkg::ST_CALC);
  // result leaves only against a credit
  assign resp_valid = (state == div_pkg::ST_DONE) && (credit_cnt != '0);

  // ----------------------------------------------------------
  // next state
  // ----------------------------------------------------------
  always_comb begin
    state_next = state;
    case (state)
      div_pkg::ST_IDLE: begin
        if (deq_pop) begin
          state_next = div_pkg::ST_CALC;
        end
      end
      div_pkg::ST_CALC: begin
        // last step runs with the counter at zero
        if (count_zero) begin
          state_next = div_pkg::ST_DONE;
        end
      end
      div_pkg::ST_DONE: begin
        if (resp_valid) begin
          state_next = div_pkg::ST_IDLE;
        end
      end
      default: state_next = div_pkg::ST_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= div_pkg::ST_IDLE;
    end else begin
      state <= state_next;
    end
  end

  // ----------------------------------------------------------
  // response credit counter
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      credit_cnt <= '0;
    end else if (resp_credit && !resp_valid) begin
      credit_cnt <= credit_cnt + 1'b1;
    end else if (!resp_credit && resp_valid) begin
      credit_cnt <= credit_cnt - 1'b1;
    end
  end

  // pop to done is fixed at 33 cycles, counter lives in the datapath
  a_calc_latency: assert property (@(posedge clk) disable iff (reset)
    deq_pop |-> ##33 (state == div_pkg::ST_DONE));

  // sink granted more credits than the counter can hold
  a_credit_overflow: assert property (@(posedge clk) disable iff (reset)
    (resp_credit && !resp_valid) |-> (credit_cnt != '1));

  // keep or restore choice must be known on every step
  a_sub_neg_known: assert property (@(posedge clk) disable iff (reset)
    step |-> !$isunknown(sub_neg));

endmodule

`default_nettype wire

//--- design/div_dpath.sv
/*
  divider datapath
  operand magnitudes, restoring shift-subtract, step counter and sign fix-up
*/
`timescale 1ns/1ps
`default_nettype none

`include "div_macros.svh"

module div_dpath (
  input  logic              clk,
  input  logic              reset,
  input  logic              load,
  input  logic              step,
  input  div_pkg::div_req_t deq_req,
  output div_pkg::div_resp_t resp,
  output logic              sub_neg,
  output logic              count_zero
);

  localparam int XLEN  = `DIV_XLEN;
  localparam int RQ_W  = 2 * XLEN + 1;
  localparam int CNT_W = $clog2(XLEN);

  // remainder in the upper half, quotient shifts in at the bottom
  logic [RQ_W-1:0]  rq_reg;
  logic [XLEN-1:0]  b_reg;
  logic             quot_neg;
  logic             rem_neg;
  logic [CNT_W-1:0] cnt;

  // ----------------------------------------------------------
  // operand normalization
  // ----------------------------------------------------------

  // sign flags only count for a signed request
  logic            a_neg;
  logic            b_neg;
  logic [XLEN-1:0] a_mag;
  logic [XLEN-1:0] b_mag;

  assign a_neg = (deq_req.fn == div_pkg::DIV_SIGNED) && deq_req.a[XLEN-1];
  assign b_neg = (deq_req.fn == div_pkg::DIV_SIGNED) && deq_req.b[XLEN-1];
  // most negative value stays 0x80000000, correct as an unsigned magnitude
  assign a_mag = a_neg ? (~deq_req.a + 1'b1) : deq_req.a;
  assign b_mag = b_neg ? (~deq_req.b + 1'b1) : deq_req.b;

  // ----------------------------------------------------------
  // one shift-subtract step
  // ----------------------------------------------------------
  logic [RQ_W-1:0] shifted;
  logic [RQ_W-1:0] sub_out;

  assign shifted = rq_reg << 1;
  // divisor aligned with the remainder half
  assign sub_out = shifted - {1'b0, b_reg, {XLEN{1'b0}}};
  // borrow out means the divisor did not fit
  assign sub_neg = sub_out[RQ_W-1];

  // payload registers
  always_ff @(posedge clk) begin
    if (load) begin
      rq_reg   <= {{(XLEN + 1){1'b0}}, a_mag};
      b_reg    <= b_mag;
      quot_neg <= a_neg ^ b_neg;
      rem_neg  <= a_neg;
    end else if (step) begin
      // keep the difference and shift in a 1, or restore and shift in a 0
      rq_reg <= sub_neg ? {shifted[RQ_W-1:1], 1'b0} : {sub_out[RQ_W-1:1], 1'b1};
    end
  end

  // step counter, 31 down to 0
  always_ff @(posedge clk) begin
    if (reset) begin
      cnt <= '0;
    end else if (load) begin
      cnt <= CNT_W'(XLEN - 1);
    end else if (step) begin
      cnt <= cnt - 1'b1;
    end
  end

  assign count_zero = (cnt == '0);

  // ----------------------------------------------------------
  // sign correction
  // ----------------------------------------------------------
  logic [XLEN-1:0] quot_raw;
  logic [XLEN-1:0] rem_raw;

  assign quot_raw = rq_reg[XLEN-1:0];
  assign rem_raw  = rq_reg[2*XLEN-1:XLEN];

  // quotient negated on differing signs, remainder follows the dividend
  always_comb begin
    resp.quot = quot_neg ? (~quot_raw + 1'b1) : quot_raw;
    resp.rem  = rem_neg ? (~rem_raw + 1'b1) : rem_raw;
  end

endmodule

`default_nettype wire

//--- design/div_unit.sv
/*
  iterative divide unit top
  request queue in front of the divider, credit flow control on both sides
*/
`timescale 1ns/1ps
`default_nettype none

`include "div_macros.svh"

module div_unit (
  input  logic               clk,
  input  logic               reset,
  input  logic               req_valid,
  input  div_pkg::div_req_t  req,
  output logic               req_credit,
  output logic               resp_valid,
  output div_pkg::div_resp_t resp,
  input  logic               resp_credit
);

  // queue to divider
  logic              deq_valid;
  logic              deq_pop;
  div_pkg::div_req_t deq_req;

  // control to datapath and back
  logic load;
  logic step;
  logic sub_neg;
  logic count_zero;

  // ----------------------------------------------------------
  // request buffer
  // ----------------------------------------------------------
  div_req_queue #(
    .DEPTH (`DIV_QUEUE_DEPTH)
  ) u_queue (
    .clk        (clk),
    .reset      (reset),
    .req_valid  (req_valid),
    .req        (req),
    .deq_pop    (deq_pop),
    .deq_valid  (deq_valid),
    .deq_req    (deq_req),
    .req_credit (req_credit)
  );

  // ----------------------------------------------------------
  // divider
  // ----------------------------------------------------------
  div_ctrl u_ctrl (
    .clk         (clk),
    .reset       (reset),
    .deq_valid   (deq_valid),
    .deq_pop     (deq_pop),
    .resp_credit (resp_credit),
    .resp_valid  (resp_valid),
    .sub_neg     (sub_neg),
    .count_zero  (count_zero),
    .load        (load),
    .step        (step)
  );

  div_dpath u_dpath (
    .clk        (clk),
    .reset      (reset),
    .load       (load),
    .step       (step),
    .deq_req    (deq_req),
    .resp       (resp),
    .sub_neg    (sub_neg),
    .count_zero (count_zero)
  );

endmodule

`default_nettype wire

//--- testbench/tb_clkgen.sv
/*
  testbench clock and reset source
*/
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
  parameter int PERIOD_NS    = 20,
  parameter int RESET_CYCLES = 3
) (
  output logic clk,
  output logic reset
);

  // free running clock, starts low
  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // reset released just after a rising edge, like every other input
  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #2;
    reset = 1'b0;
  end

endmodule

`default_nettype wire

//--- testbench/tb_div_unit.sv
/*
  divide unit testbench
  random requests against a reference model with credits checked on both sides
*/
`timescale 1ns/1ps
`default_nettype none

`include "div_macros.svh"

module tb_div_unit;

  localparam int NUM_REQ        = 120;
  localparam int DEPTH          = `DIV_QUEUE_DEPTH;
  localparam int CRED_W         = `DIV_CREDIT_W;
  localparam int RESET_TIMEOUT  = 20;
  localparam int STIM_TIMEOUT   = 200000;
  localparam int DRAIN_TIMEOUT  = 5000;
  localparam int CREDIT_TIMEOUT = 100;
  localparam logic [`DIV_XLEN-1:0] MIN_NEG = {1'b1, {(`DIV_XLEN - 1){1'b0}}};

  logic               clk;
  logic               reset;
  logic               req_valid;
  div_pkg::div_req_t  req;
  logic               req_credit;
  logic               resp_valid;
  div_pkg::div_resp_t resp;
  logic               resp_credit;

  // ----------------------------------------------------------
  // testbench state
  // ----------------------------------------------------------
  logic [31:0]        rng_state;
  int                 req_credits;
  // response credits granted and not yet used by the DUT
  int                 resp_credits;
  int                 sent;
  int                 received;
  int                 hold_cycles;
  int                 cycles;
  div_pkg::div_resp_t exp_q [$];

  tb_clkgen #(
    .PERIOD_NS    (20),
    .RESET_CYCLES (3)
  ) u_clkgen (
    .clk   (clk),
    .reset (reset)
  );

  div_unit dut0 (
    .clk         (clk),
    .reset       (reset),
    .req_valid   (req_valid),
    .req         (req),
    .req_credit  (req_credit),
    .resp_valid  (resp_valid),
    .resp        (resp),
    .resp_credit (resp_credit)
  );

  // ----------------------------------------------------------
  // failure handling and compare tasks
  // ----------------------------------------------------------
  task automatic fail_stop();
    $display("TEST FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic abort_run(input string what);
    $display("%s", what);
    fail_stop();
  endtask

  task automatic check_resp(input div_pkg::div_resp_t exp, input div_pkg::div_resp_t got);
    if (got.quot !== exp.quot) begin
      $display("ERR resp.quot exp=%h got=%h", exp.quot, got.quot);
      fail_stop();
    end
    if (got.rem !== exp.rem) begin
      $display("ERR resp.rem exp=%h got=%h", exp.rem, got.rem);
      fail_stop();
    end
  endtask

  task automatic check_credit_count(input string name, input logic [CRED_W-1:0] exp,
                                    input logic [CRED_W-1:0] got);
    if (got !== exp) begin
      $display("ERR %s exp=%h got=%h", name, exp, got);
      fail_stop();
    end
  endtask

  // ----------------------------------------------------------
  // random numbers and reference model
  // ----------------------------------------------------------

  // two LCG steps keeping only the upper halves since the low bits cycle quickly
  function automatic logic [31:0] next_rand();
    logic [15:0] hi;
    rng_state = rng_state * 32'h0019660d + 32'h3c6ef35f;
    hi        = rng_state[31:16];
    rng_state = rng_state * 32'h0019660d + 32'h3c6ef35f;
    return {hi, rng_state[31:16]};
  endfunction

  function automatic div_pkg::div_req_t make_req();
    div_pkg::div_req_t r;
    logic [31:0]       sel;
    sel  = next_rand();
    r.fn = sel[0] ? div_pkg::DIV_SIGNED : div_pkg::DIV_UNSIGNED;
    r.a  = next_rand();
    // shorter divisors give wider quotients
    r.b  = next_rand() >> sel[8:4];
    if (sel[20]) begin
      r.b = -r.b;
    end
    // overflow corner now and then
    if (sel[15:12] == 4'd0) begin
      r.fn = div_pkg::DIV_SIGNED;
      r.a  = MIN_NEG;
      r.b  = '1;
    end
    // zero divisor is outside the unit's range
    if (r.b == '0) begin
      r.b = 1;
    end
    return r;
  endfunction

  // truncating division with the remainder carrying the dividend sign
  function automatic div_pkg::div_resp_t model_div(input div_pkg::div_req_t r);
    div_pkg::div_resp_t        e;
    logic signed [`DIV_XLEN-1:0] sa;
    logic signed [`DIV_XLEN-1:0] sb;
    sa = r.a;
    sb = r.b;
    if (r.fn == div_pkg::DIV_UNSIGNED) begin
      e.quot = r.a / r.b;
      e.rem  = r.a % r.b;
    end else if (r.a == MIN_NEG && r.b == '1) begin
      e.quot = MIN_NEG;
      e.rem  = '0;
    end else begin
      e.quot = sa / sb;
      e.rem  = sa % sb;
    end
    return e;
  endfunction

  // ----------------------------------------------------------
  // one cycle of stimulus per call
  // ----------------------------------------------------------
  task automatic drive_cycle();
    div_pkg::div_req_t r;
    logic [31:0]       roll;
    @(posedge clk);
    #2;
    req_valid   = 1'b0;
    resp_credit = 1'b0;
    roll        = next_rand();
    // opening burst fills the queue and a random request rate follows
    if (sent < NUM_REQ && req_credits > 0 && (sent < DEPTH || roll[31:30] != 2'b00)) begin
      r         = make_req();
      req       = r;
      req_valid = 1'b1;
      exp_q.push_back(model_div(r));
      req_credits--;
      sent++;
    end
    // response credits with long random gaps
    if (hold_cycles > 0) begin
      hold_cycles--;
    end else begin
      if (resp_credits < 4 && roll[27:26] == 2'b00) begin
        resp_credit = 1'b1;
      end
      if (roll[23:17] == 7'd0) begin
        hold_cycles = 40 + roll[14:8];
      end
    end
  endtask

  // ----------------------------------------------------------
  // output monitor at mid cycle where outputs are settled
  // ----------------------------------------------------------
  always @(negedge clk) begin : monitor
    div_pkg::div_resp_t exp;
    if (!reset) begin
      check_credit_count("credit_cnt", CRED_W'(resp_credits), dut0.u_ctrl.credit_cnt);
      if (resp_valid) begin
        if (resp_credits == 0) begin
          abort_run("resp_valid seen without a granted response credit");
        end
        if (exp_q.size() == 0) begin
          abort_run("resp_valid seen with no request outstanding");
        end
        exp = exp_q.pop_front();
        check_resp(exp, resp);
        resp_credits--;
        received++;
      end
      // a credit granted this cycle is usable from the next one
      if (resp_credit) begin
        resp_credits++;
      end
      if (req_credit) begin
        req_credits++;
        if (req_credits > DEPTH) begin
          abort_run("more request credits returned than were spent");
        end
      end
    end
  end

  // ----------------------------------------------------------
  // test sequence
  // ----------------------------------------------------------
  initial begin
    req_valid    = 1'b0;
    req          = '0;
    resp_credit  = 1'b0;
    rng_state    = 32'h9af0;
    req_credits  = DEPTH;
    resp_credits = 0;
    sent         = 0;
    received     = 0;
    // no response credit early on so results must wait
    hold_cycles  = 80;

    // reset is looked at on clock edges only
    cycles = 0;
    do begin
      @(posedge clk);
      cycles++;
      if (cycles > RESET_TIMEOUT) begin
        abort_run("reset was never released");
      end
    end while (reset !== 1'b0);

    cycles = 0;
    while (sent < NUM_REQ) begin
      drive_cycle();
      cycles++;
      if (cycles > STIM_TIMEOUT) begin
        abort_run("timeout: requests could not all be sent, request credits stuck");
      end
    end

    // keep granting credits until every result is back
    cycles = 0;
    while (received < NUM_REQ) begin
      drive_cycle();
      cycles++;
      if (cycles > DRAIN_TIMEOUT) begin
        abort_run("timeout: not every result arrived");
      end
    end

    cycles = 0;
    while (req_credits != DEPTH) begin
      @(posedge clk);
      cycles++;
      if (cycles > CREDIT_TIMEOUT) begin
        abort_run("timeout: request credits did not all return");
      end
    end

    $display("TEST PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- sources.f
+incdir+design
design/div_pkg.sv
design/div_req_queue.sv
design/div_ctrl.sv
design/div_dpath.sv
design/div_unit.sv
testbench/tb_clkgen.sv
testbench/tb_div_unit.sv

//--- Makefile
# Verilator build and run for the divide unit testbench

VERILATOR ?= verilator
TOP       ?= tb_div_unit
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 ; cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "TEST PASSED" $(LOG) || (echo "no pass line found in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
